// ==== rtl/backoff_params.svh ====
`ifndef BACKOFF_PARAMS_SVH
`define BACKOFF_PARAMS_SVH

////////////////////////////////////////////////////////////
// Backoff AC selector sizing
////////////////////////////////////////////////////////////

// EDCA queues AC0 to AC3
`define AC_NUM 4

// QSRC and QLRC width
`define RETRY_CNT_W 8

// TXOP limit and medium occupancy timer width
`define TIMER_W 16

// One-hot DMA channel state
`define DMA_STATE_W 4

`endif

// ==== rtl/backoffPkg.sv ====
`include "backoff_params.svh"

package backoffPkg;

  // DMA channel state, one-hot
  typedef enum logic [`DMA_STATE_W-1:0] {
    HALTED  = 4'b0001,  // Reset state, SW not ready
    PASSIVE = 4'b0010,  // Waiting for a MAC controller trigger
    ACTIVE  = 4'b0100,  // DMA transfer ongoing
    DEAD    = 4'b1000   // Error state
  } dmaState_e;

  // EDCA queue index, AC3 has the highest priority
  typedef enum logic [1:0] {
    AC0 = 2'd0,
    AC1 = 2'd1,
    AC2 = 2'd2,
    AC3 = 2'd3
  } acIndex_e;

  // Register view of one queue
  typedef struct packed {
    dmaState_e             dmaState;
    logic [`TIMER_W-1:0]   txOpLimit;
  } acQueue_t;
  typedef acQueue_t [`AC_NUM-1:0] acQueueVec_t;

  // Tx controller status pulses
  typedef struct packed {
    logic txSuccessful_p;
    logic retry_p;
    logic retryLtReached_p;
    logic retryType;         // 1 for long retry
  } txStatus_t;

  // Per queue retry counters
  typedef struct packed {
    logic [`RETRY_CNT_W-1:0] qsrc;
    logic [`RETRY_CNT_W-1:0] qlrc;
  } acRetryCnt_t;
  typedef acRetryCnt_t [`AC_NUM-1:0] acRetryCntVec_t;

  // Per queue status pulses
  typedef struct packed {
    logic txSuccessful_p;
    logic txFailed_p;
    logic retryLtReached_p;
  } acEvent_t;
  typedef acEvent_t [`AC_NUM-1:0] acEventVec_t;

  typedef logic [`AC_NUM-1:0][`TIMER_W-1:0] acMotVec_t;

endpackage

// ==== rtl/backoffTrigCapture.sv ====
`timescale 1ns/1ps
`include "backoff_params.svh"

module backoffTrigCapture (
  input  logic                    macCoreClk,
  input  logic                    macCoreClkHardRst_n,
  input  logic                    tickDMAEarlySlot_p,   // From timer block
  input  logic                    macPhyIfRxCca,        // CCA from PHY
  input  logic                    channelBusy,          // NAV busy
  input  logic                    txInProgress,
  input  logic [`AC_NUM-1:0]      backoffDone,          // Counter expired, per queue
  input  backoffPkg::acQueueVec_t acQueue,
  input  logic                    startTxFrameEx,       // SW start request
  input  backoffPkg::acIndex_e    startTxAC,            // Queue named by SW
  input  logic                    indexValid,           // Arbiter has the winner
  output logic [`AC_NUM-1:0]      capturedAc,
  output logic                    startIndexCalc_p
);
  import backoffPkg::*;

  logic               tickDelayed_p;  // Early slot, one cycle late
  logic               mediumIdle;
  logic [`AC_NUM-1:0] qualify;        // Queues allowed to contend

  ////////////////////////////////////////////////////////////
  // Slot tick alignment
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      tickDelayed_p <= 1'b0;
    else
      tickDelayed_p <= tickDMAEarlySlot_p;
  end

  // No Rx, no NAV and no Tx
  assign mediumIdle = !(macPhyIfRxCca || channelBusy || txInProgress);

  // Expired counter and a ready DMA, or a SW request on that queue
  always_comb
  begin
    for (int i = 0; i < `AC_NUM; i++)
    begin
      qualify[i] = backoffDone[i] &&
                   ((acQueue[i].dmaState == PASSIVE) ||
                    (startTxFrameEx && (startTxAC == 2'(i))));
    end
  end

  ////////////////////////////////////////////////////////////
  // Capture register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      capturedAc       <= '0;
      startIndexCalc_p <= 1'b0;
    end
    else if (tickDelayed_p && mediumIdle)
    begin
      capturedAc       <= capturedAc | qualify;
      startIndexCalc_p <= |qualify;       // Launch arbitration only if someone contends
    end
    else
    begin
      if (indexValid)
        capturedAc <= '0;                 // Winner known, drop the snapshot
      startIndexCalc_p <= 1'b0;
    end
  end

endmodule

// ==== rtl/acPriorityArbiter.sv ====
`timescale 1ns/1ps
`include "backoff_params.svh"

module acPriorityArbiter (
  input  logic                   macCoreClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic [`AC_NUM-1:0]     capturedAc,        // Queues that won the slot
  input  logic                   startIndexCalc_p,  // Snapshot just taken
  output logic                   indexValid,
  output backoffPkg::acIndex_e   winnerIdx,
  output logic                   winnerDone_p,      // Backoff done for the winner
  output logic [`AC_NUM-2:0]     internalColl_p     // Virtual collision, AC0 to AC2
);
  import backoffPkg::*;

  acIndex_e highIdx;  // Highest captured queue

  ////////////////////////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    casez (capturedAc)
      4'b1???: highIdx = AC3;
      4'b01??: highIdx = AC2;
      4'b001?: highIdx = AC1;
      default: highIdx = AC0;
    endcase
  end

  // Index register, held until the next snapshot
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      winnerIdx  <= AC0;
      indexValid <= 1'b0;
    end
    else
    begin
      if (startIndexCalc_p)
        winnerIdx <= highIdx;
      indexValid <= startIndexCalc_p;   // One cycle flag
    end
  end

  ////////////////////////////////////////////////////////////
  // Done and collision pulses
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      winnerDone_p   <= 1'b0;
      internalColl_p <= '0;
    end
    else
    begin
      winnerDone_p <= indexValid;
      // Any other contender lost against a higher queue
      for (int i = 0; i < `AC_NUM - 1; i++)
      begin
        internalColl_p[i] <= indexValid && capturedAc[i] && (winnerIdx != 2'(i));
      end
    end
  end

endmodule

// ==== rtl/txTriggerCtrl.sv ====
`timescale 1ns/1ps
`include "backoff_params.svh"

module txTriggerCtrl (
  input  logic                   macCoreClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic                   winnerDone_p,     // From arbiter
  input  backoffPkg::acIndex_e   winnerIdx,
  input  backoffPkg::txStatus_t  txStatus,         // Tx controller pulses
  input  logic                   macPhyIfRxCca,
  input  logic                   channelBusy,
  input  logic                   txInProgress,
  input  logic                   tickEarlySlot_p,  // MAC controller slot tick
  output logic [`AC_NUM-1:0]     trigTxAC,         // DMA trigger, level
  output logic                   backOffDone_p,    // To MAC controller
  output backoffPkg::acIndex_e   activeAC
);
  import backoffPkg::*;

  logic anyTrig;      // One DMA channel already armed
  logic txRelease;    // Frame exchange over or Rx outside a TXOP
  logic trigMacCtrl;  // MAC controller still owed a backoff done

  assign anyTrig   = |trigTxAC;
  assign txRelease = txStatus.txSuccessful_p   ||
                     txStatus.retry_p          ||
                     txStatus.retryLtReached_p ||
                     (macPhyIfRxCca && !txInProgress);

  ////////////////////////////////////////////////////////////
  // Active AC
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      activeAC <= AC0;
    else if (winnerDone_p)
      activeAC <= winnerIdx;
  end

  ////////////////////////////////////////////////////////////
  // DMA trigger
  ////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      trigTxAC <= '0;
    else if (anyTrig)
    begin
      // Held until the Tx controller reports
      if (txRelease)
        trigTxAC <= '0;
    end
    else if (winnerDone_p)
      trigTxAC[winnerIdx] <= 1'b1;
  end

  // MAC controller trigger, consumed on its slot tick
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      trigMacCtrl <= 1'b0;
    else if (winnerDone_p)
      trigMacCtrl <= 1'b1;
    else if (macPhyIfRxCca || channelBusy || txInProgress || backOffDone_p)
      trigMacCtrl <= 1'b0;  // Medium lost or done delivered
  end

  assign backOffDone_p = trigMacCtrl && tickEarlySlot_p;

endmodule

// ==== rtl/acStatusRouter.sv ====
`timescale 1ns/1ps
`include "backoff_params.svh"

module acStatusRouter (
  input  logic                       macCoreClk,
  input  logic                       macCoreClkHardRst_n,
  input  backoffPkg::acIndex_e       activeAC,    // Queue owning the medium
  input  backoffPkg::txStatus_t      txStatus,
  input  logic [`TIMER_W-1:0]        acMOT,       // MOT of the current TXOP
  input  backoffPkg::acQueueVec_t    acQueue,
  output backoffPkg::acEventVec_t    acEvent,
  output backoffPkg::acRetryCntVec_t acRetryCnt,
  output backoffPkg::acMotVec_t      acMotOut,
  output backoffPkg::dmaState_e      txDmaState,  // State of the active channel
  output logic [`TIMER_W-1:0]        txOpLimit    // TXOP limit of the active channel
);

  logic [`AC_NUM-1:0] acSel;  // One-hot of activeAC
  logic               cntClear;

  always_comb
  begin
    for (int i = 0; i < `AC_NUM; i++)
    begin
      acSel[i] = (activeAC == 2'(i));
    end
  end

  ////////////////////////////////////////////////////////////
  // Status steering and MOT routing
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    for (int i = 0; i < `AC_NUM; i++)
    begin
      acEvent[i].txSuccessful_p   = acSel[i] && txStatus.txSuccessful_p;
      acEvent[i].txFailed_p       = acSel[i] && txStatus.retry_p;   // Frame to be retried
      acEvent[i].retryLtReached_p = acSel[i] && txStatus.retryLtReached_p;
      acMotOut[i]                 = acSel[i] ? acMOT : acQueue[i].txOpLimit;
    end
  end

  // Active channel view for the MAC controller
  assign txDmaState = acQueue[activeAC].dmaState;
  assign txOpLimit  = acQueue[activeAC].txOpLimit;

  ////////////////////////////////////////////////////////////
  // QSRC and QLRC
  ////////////////////////////////////////////////////////////
  assign cntClear = txStatus.txSuccessful_p || txStatus.retryLtReached_p;

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      acRetryCnt <= '0;
    else
    begin
      for (int i = 0; i < `AC_NUM; i++)
      begin
        if (acSel[i])
        begin
          if (cntClear)
          begin
            acRetryCnt[i].qsrc <= '0;  // MSDU over, restart both
            acRetryCnt[i].qlrc <= '0;
          end
          else if (txStatus.retry_p)
          begin
            if (txStatus.retryType)
              acRetryCnt[i].qlrc <= acRetryCnt[i].qlrc + 1'b1;
            else
              acRetryCnt[i].qsrc <= acRetryCnt[i].qsrc + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== rtl/backoffAcSel.sv ====
`timescale 1ns/1ps
`include "backoff_params.svh"

module backoffAcSel (
  input  logic                       macCoreClk,
  input  logic                       macCoreClkHardRst_n,
  // Timer block
  input  logic                       tickDMAEarlySlot_p,
  input  logic                       tickEarlySlot_p,
  // PHY and NAV
  input  logic                       macPhyIfRxCca,
  input  logic                       channelBusy,
  // Tx controller
  input  logic                       txInProgress,
  input  backoffPkg::txStatus_t      txStatus,
  input  logic [`TIMER_W-1:0]        acMOT,
  // Register block
  input  backoffPkg::acQueueVec_t    acQueue,
  input  logic                       startTxFrameEx,
  input  backoffPkg::acIndex_e       startTxAC,
  // Backoff counters
  input  logic [`AC_NUM-1:0]         backoffDone,
  output logic [`AC_NUM-2:0]         internalColl_p,
  // DMA and MAC controller
  output logic [`AC_NUM-1:0]         trigTxAC,
  output logic                       backOffDone_p,
  output backoffPkg::acIndex_e       activeAC,
  output backoffPkg::acEventVec_t    acEvent,
  output backoffPkg::acRetryCntVec_t acRetryCnt,
  output backoffPkg::acMotVec_t      acMotOut,
  output backoffPkg::dmaState_e      txDmaState,
  output logic [`TIMER_W-1:0]        txOpLimit
);
  import backoffPkg::*;

  logic [`AC_NUM-1:0] capturedAc;
  logic               startIndexCalc_p;
  logic               indexValid;
  logic               winnerDone_p;
  acIndex_e           winnerIdx;

  ////////////////////////////////////////////////////////////
  // Capture, arbitration, trigger, status
  ////////////////////////////////////////////////////////////
  backoffTrigCapture u_capture (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .tickDMAEarlySlot_p  (tickDMAEarlySlot_p),
    .macPhyIfRxCca       (macPhyIfRxCca),
    .channelBusy         (channelBusy),
    .txInProgress        (txInProgress),
    .backoffDone         (backoffDone),
    .acQueue             (acQueue),
    .startTxFrameEx      (startTxFrameEx),
    .startTxAC           (startTxAC),
    .indexValid          (indexValid),
    .capturedAc          (capturedAc),
    .startIndexCalc_p    (startIndexCalc_p)
  );

  acPriorityArbiter u_arbiter (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .capturedAc          (capturedAc),
    .startIndexCalc_p    (startIndexCalc_p),
    .indexValid          (indexValid),
    .winnerIdx           (winnerIdx),
    .winnerDone_p        (winnerDone_p),
    .internalColl_p      (internalColl_p)
  );

  txTriggerCtrl u_trigger (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .winnerDone_p        (winnerDone_p),
    .winnerIdx           (winnerIdx),
    .txStatus            (txStatus),
    .macPhyIfRxCca       (macPhyIfRxCca),
    .channelBusy         (channelBusy),
    .txInProgress        (txInProgress),
    .tickEarlySlot_p     (tickEarlySlot_p),
    .trigTxAC            (trigTxAC),
    .backOffDone_p       (backOffDone_p),
    .activeAC            (activeAC)
  );

  acStatusRouter u_status (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .activeAC            (activeAC),
    .txStatus            (txStatus),
    .acMOT               (acMOT),
    .acQueue             (acQueue),
    .acEvent             (acEvent),
    .acRetryCnt          (acRetryCnt),
    .acMotOut            (acMotOut),
    .txDmaState          (txDmaState),
    .txOpLimit           (txOpLimit)
  );

endmodule

// ==== tb/backoffAcSel_assert.sv ====
`timescale 1ns/1ps
`include "backoff_params.svh"

module backoffAcSelAssert (
  input  logic                 macCoreClk,
  input  logic                 macCoreClkHardRst_n,
  input  logic                 winnerDone_p,    // Arbiter done pulse
  input  backoffPkg::acIndex_e winnerIdx,       // Held winner index
  input  logic [`AC_NUM-2:0]   internalColl_p,  // AC0 to AC2 collisions
  input  logic [`AC_NUM-1:0]   trigTxAC         // DMA triggers
);
  import backoffPkg::*;

  logic [`AC_NUM-1:0] collVec;  // Collisions padded to four queues

  assign collVec = {1'b0, internalColl_p};  // AC3 never collides

  ////////////////////////////////////////////////////////////
  // Pulse widths
  ////////////////////////////////////////////////////////////
  doneOneCycle: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    winnerDone_p |=> !winnerDone_p)
    else $error("winnerDone_p stayed high for more than one cycle");

  collOneCycle: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (|internalColl_p) |=> !(|internalColl_p))
    else $error("internalColl_p stayed high for more than one cycle");

  ////////////////////////////////////////////////////////////
  // Trigger and collision consistency
  ////////////////////////////////////////////////////////////
  // Only one DMA channel armed at a time
  trigOneHot: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    $onehot0(trigTxAC))
    else $error("More than one trigTxAC bit is high");

  // Losers rank below the winner, never at or above it
  collNotWinner: assert property (@(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (|internalColl_p) |-> ((collVec >> winnerIdx) == '0))
    else $error("Collision pulse sent to the winning queue or a higher one");

endmodule

// Top level sees the arbiter and the trigger outputs together
bind backoffAcSel backoffAcSelAssert u_assert (
  .macCoreClk          (macCoreClk),
  .macCoreClkHardRst_n (macCoreClkHardRst_n),
  .winnerDone_p        (winnerDone_p),
  .winnerIdx           (winnerIdx),
  .internalColl_p      (internalColl_p),
  .trigTxAC            (trigTxAC)
);

// ==== tb/backoffAcSelTb.sv ====
`timescale 1ns/1ps
`include "backoff_params.svh"

module backoffAcSelTb;
  import backoffPkg::*;

  localparam int ClkHalf       = 4;     // 8 ns period
  localparam int TimeoutCycles = 2000;  // Whole run needs about 120 cycles

  logic                   macCoreClk;
  logic                   macCoreClkHardRst_n;
  logic                   tickDMAEarlySlot_p;
  logic                   tickEarlySlot_p;
  logic                   macPhyIfRxCca;
  logic                   channelBusy;
  logic                   txInProgress;
  txStatus_t              txStatus;
  logic [`TIMER_W-1:0]    acMOT;
  acQueueVec_t            acQueue;
  logic                   startTxFrameEx;
  acIndex_e               startTxAC;
  logic [`AC_NUM-1:0]     backoffDone;
  logic [`AC_NUM-2:0]     internalColl_p;
  logic [`AC_NUM-1:0]     trigTxAC;
  logic                   backOffDone_p;
  acIndex_e               activeAC;
  acEventVec_t            acEvent;
  acRetryCntVec_t         acRetryCnt;
  acMotVec_t              acMotOut;
  dmaState_e              txDmaState;
  logic [`TIMER_W-1:0]    txOpLimit;

  int     errors;
  int     checks;
  int     cycleCnt;
  integer seed;

  backoffAcSel u_dut (.*);

  always #ClkHalf macCoreClk = ~macCoreClk;

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////
  always @(posedge macCoreClk)
  begin
    cycleCnt = cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles)
    begin
      $display("Timeout: tests still running after %0d cycles", cycleCnt);
      $display("tests failed");
      $finish;
    end
  end

  task checkEq(input string name, input logic [63:0] got, input logic [63:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
    end
  endtask

  // Next edge plus drive skew
  task nextCycle();
    @(posedge macCoreClk);
    #1;
  endtask

  // One queue's expected status pulses, others quiet
  function automatic acEventVec_t eventFor(acIndex_e idx, logic succ, logic fail, logic lim);
    acEventVec_t ev;
    ev      = '0;
    ev[idx] = '{succ, fail, lim};
    return ev;
  endfunction

  // DMA early slot tick, then wait up to 10 cycles for a trigger
  task runSlot(input logic [`AC_NUM-1:0] ready, output int trigCycle,
               output logic [`AC_NUM-2:0] collSeen);
    trigCycle          = 0;
    collSeen           = '0;
    backoffDone        = ready;
    tickDMAEarlySlot_p = 1'b1;
    for (int i = 1; i <= 10 && trigCycle == 0; i++)
    begin
      nextCycle();
      tickDMAEarlySlot_p = 1'b0;     // Single cycle tick
      collSeen = collSeen | internalColl_p;
      if (trigTxAC != '0)
        trigCycle = i;
    end
    backoffDone = '0;
  endtask

  // Success pulse frees the armed channel
  task releaseTrig();
    txStatus.txSuccessful_p = 1'b1;
    nextCycle();
    txStatus = '0;
    checkEq("trigTxAC", 64'(trigTxAC), 64'(0));
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task testSingleWin();
    int                 trigCycle;
    logic [`AC_NUM-2:0] coll;
    acQueue[2].dmaState = PASSIVE;
    runSlot(4'b0100, trigCycle, coll);
    checkEq("trigTxAC", 64'(trigTxAC), 64'(4'b0100));
    checkEq("trigCycle", 64'(trigCycle), 64'(5));  // T+5
    checkEq("activeAC", 64'(activeAC), 64'(AC2));
    checkEq("internalColl_p", 64'(coll), 64'(0));
    tickEarlySlot_p = 1'b1;
    #1;
    checkEq("backOffDone_p", 64'(backOffDone_p), 64'(1));
    nextCycle();
    checkEq("backOffDone_p", 64'(backOffDone_p), 64'(0));  // Delivered once
    tickEarlySlot_p = 1'b0;
    releaseTrig();
    acQueue[2].dmaState = HALTED;
  endtask

  task testCollision();
    int                 trigCycle;
    logic [`AC_NUM-2:0] coll;
    acQueue[0].dmaState = PASSIVE;
    acQueue[3].dmaState = PASSIVE;
    runSlot(4'b1001, trigCycle, coll);
    checkEq("internalColl_p", 64'(coll), 64'(3'b001));  // AC0 loses
    checkEq("trigTxAC", 64'(trigTxAC), 64'(4'b1000));
    checkEq("activeAC", 64'(activeAC), 64'(AC3));
    releaseTrig();
    acQueue[0].dmaState = HALTED;
    acQueue[3].dmaState = HALTED;
  endtask

  task testBusyMedium();
    int                 trigCycle;
    logic [`AC_NUM-2:0] coll;
    acQueue[1].dmaState = PASSIVE;
    channelBusy         = 1'b1;  // NAV set across the delayed tick
    runSlot(4'b0010, trigCycle, coll);
    checkEq("trigCycle", 64'(trigCycle), 64'(0));
    checkEq("trigTxAC", 64'(trigTxAC), 64'(0));
    channelBusy         = 1'b0;
    acQueue[1].dmaState = HALTED;
  endtask

  task testSoftwareStart();
    int                 trigCycle;
    logic [`AC_NUM-2:0] coll;
    startTxFrameEx = 1'b1;       // AC1 stays HALTED
    startTxAC      = AC1;
    runSlot(4'b0010, trigCycle, coll);
    startTxFrameEx = 1'b0;
    checkEq("trigTxAC", 64'(trigTxAC), 64'(4'b0010));
    checkEq("activeAC", 64'(activeAC), 64'(AC1));
    checkEq("txDmaState", 64'(txDmaState), 64'(HALTED));
  endtask

  // Runs on AC1, left active by the software start
  task testRetryAccounting();
    acRetryCntVec_t expCnt;
    txStatus.retry_p   = 1'b1;
    txStatus.retryType = 1'b0;   // Short retry
    #1;
    checkEq("acEvent", 64'(acEvent), 64'(eventFor(AC1, 1'b0, 1'b1, 1'b0)));
    nextCycle();
    checkEq("trigTxAC", 64'(trigTxAC), 64'(0));  // Any status pulse frees the channel
    txStatus           = '0;
    txStatus.retry_p   = 1'b1;
    txStatus.retryType = 1'b1;   // Long retry
    #1;
    checkEq("acEvent", 64'(acEvent), 64'(eventFor(AC1, 1'b0, 1'b1, 1'b0)));
    nextCycle();
    txStatus           = '0;
    expCnt             = '0;
    expCnt[1].qsrc     = 8'd1;
    expCnt[1].qlrc     = 8'd1;
    checkEq("acRetryCnt", 64'(acRetryCnt), 64'(expCnt));
    txStatus.txSuccessful_p = 1'b1;
    #1;
    checkEq("acEvent", 64'(acEvent), 64'(eventFor(AC1, 1'b1, 1'b0, 1'b0)));
    nextCycle();
    txStatus = '0;
    checkEq("acRetryCnt", 64'(acRetryCnt), 64'(0));
    checkEq("trigTxAC", 64'(trigTxAC), 64'(0));
  endtask

  task testTimerRouting();
    int                  trigCycle;
    logic [`AC_NUM-2:0]  coll;
    logic [`TIMER_W-1:0] expMot;
    for (int i = 0; i < `AC_NUM; i++)
      acQueue[i].txOpLimit = 16'($random(seed));
    acQueue[2].dmaState = PASSIVE;
    runSlot(4'b0100, trigCycle, coll);
    checkEq("activeAC", 64'(activeAC), 64'(AC2));
    acMOT = 16'($random(seed));
    #1;
    for (int i = 0; i < `AC_NUM; i++)
    begin
      expMot = (i == 2) ? acMOT : acQueue[i].txOpLimit;  // Active queue sees the MOT
      checkEq($sformatf("acMotOut[%0d]", i), 64'(acMotOut[i]), 64'(expMot));
    end
    checkEq("txOpLimit", 64'(txOpLimit), 64'(acQueue[2].txOpLimit));
    checkEq("txDmaState", 64'(txDmaState), 64'(PASSIVE));  // Only AC2 is PASSIVE
    releaseTrig();
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    errors              = 0;
    checks              = 0;
    cycleCnt            = 0;
    seed                = 32'h32c1_7c8d;
    macCoreClk          = 1'b0;
    macCoreClkHardRst_n = 1'b0;
    tickDMAEarlySlot_p  = 1'b0;
    tickEarlySlot_p     = 1'b0;
    macPhyIfRxCca       = 1'b0;
    channelBusy         = 1'b0;
    txInProgress        = 1'b0;
    txStatus            = '0;
    acMOT               = '0;
    startTxFrameEx      = 1'b0;
    startTxAC           = AC0;
    backoffDone         = '0;
    for (int i = 0; i < `AC_NUM; i++)
      acQueue[i] = '{HALTED, 16'h0000};
    repeat (5) @(posedge macCoreClk);
    #1 macCoreClkHardRst_n = 1'b1;
    nextCycle();
    checkEq("trigTxAC", 64'(trigTxAC), 64'(0));   // Reset values
    checkEq("activeAC", 64'(activeAC), 64'(AC0));
    checkEq("acRetryCnt", 64'(acRetryCnt), 64'(0));
    checkEq("internalColl_p", 64'(internalColl_p), 64'(0));
    testSingleWin();
    testCollision();
    testBusyMedium();
    testSoftwareStart();
    testRetryAccounting();
    testTimerRouting();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/backoffPkg.sv
rtl/backoffTrigCapture.sv
rtl/acPriorityArbiter.sv
rtl/txTriggerCtrl.sv
rtl/acStatusRouter.sv
rtl/backoffAcSel.sv
tb/backoffAcSel_assert.sv
tb/backoffAcSelTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the backoff AC selector testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f project.f --top-module backoffAcSelTb \
  --Mdir obj_dir -o simv > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0
